//--- bench/tb_rv_core.sv
`default_nettype none

`include "rv_defines.svh"

module tb_rv_core;

  timeunit 1ns;
  timeprecision 100ps;

  // Result classes of the reference model
  localparam int KIND_RETIRE  = 0;
  localparam int KIND_EBREAK  = 1;
  localparam int KIND_ILLEGAL = 2;

  // Loop bounds for every wait on the core
  localparam int RUN_LIMIT   = 200;
  localparam int HALT_LIMIT  = 8;
  localparam int PARK_CYCLES = 5;

  // Fixed EBREAK encoding from the ISA
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

  logic                       clk;
  logic                       rst;
  logic                       start;
  logic                       load_we;
  logic [`RV_IMEM_ADDR_W-1:0] load_addr;
  rv_pkg::word_t              load_data;
  rv_pkg::word_t              current_pc;
  logic                       retire_valid;
  rv_pkg::reg_idx_t           retire_rd;
  rv_pkg::word_t              retire_data;
  logic                       halted;
  logic                       trapped;

  // Model state and the program image
  rv_pkg::word_t model_regs [`RV_REG_COUNT];
  rv_pkg::word_t model_pc;
  rv_pkg::word_t prog [`RV_IMEM_DEPTH];
  int            prog_len;
  logic [31:0]   lfsr_state;

  rv_core_top DUT (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .load_we      (load_we),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .current_pc   (current_pc),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halted       (halted),
    .trapped      (trapped)
  );

  always #5 clk = ~clk;

  // ********************************************************************
  // Failure reporting and compare tasks
  // ********************************************************************

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Finished with errors");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_word(input string test, input string what,
                            input rv_pkg::word_t expected, input rv_pkg::word_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED test=%s %s expected=%h actual=%h",
                          test, what, expected, actual));
    end
  endtask

  task automatic check_reg_idx(input string test, input string what,
                               input rv_pkg::reg_idx_t expected, input rv_pkg::reg_idx_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED test=%s %s expected=%0d actual=%0d",
                          test, what, expected, actual));
    end
  endtask

  task automatic check_flag(input string test, input string what,
                            input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED test=%s %s expected=%b actual=%b",
                          test, what, expected, actual));
    end
  endtask

  // ********************************************************************
  // Random source and reference model
  // ********************************************************************

  // Galois LFSR, x^32+x^22+x^2+x+1, one step per bit taken
  function automatic rv_pkg::word_t rand_bits(input int count);
    rv_pkg::word_t value;
    logic          out_bit;
    value = '0;
    for (int i = 0; i < count; i++) begin
      out_bit    = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      value = {value[30:0], out_bit};
    end
    return value;
  endfunction

  // Integer ops by funct3, returns 0 for encodings outside the subset
  function automatic logic alu_model(input logic [2:0] f3, input logic sub,
                                     input rv_pkg::word_t a, input rv_pkg::word_t b,
                                     output rv_pkg::word_t y);
    y = '0;
    alu_model = 1'b1;
    if (sub) begin
      y = a - b;
    end else begin
      case (f3)
        3'b000: y = a + b;
        3'b010: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100: y = a ^ b;
        3'b110: y = a | b;
        3'b111: y = a & b;
        default: alu_model = 1'b0;
      endcase
    end
  endfunction

  // One instruction against the model registers, no state change here
  function automatic int model_step(input rv_pkg::word_t inst, input rv_pkg::word_t pc,
                                    output rv_pkg::retire_t res);
    rv_pkg::word_t src_a;
    rv_pkg::word_t src_b;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_u;
    rv_pkg::word_t value;
    logic          ok;
    int            kind;
    src_a = model_regs[inst[19:15]];
    src_b = model_regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_u = {inst[31:12], 12'b0};
    value = '0;
    ok    = 1'b0;
    kind  = KIND_ILLEGAL;
    case (inst[6:0])
      7'b0110111: begin
        value = imm_u;
        ok    = 1'b1;
      end
      7'b0010111: begin
        value = pc + imm_u;
        ok    = 1'b1;
      end
      7'b0010011: ok = alu_model(inst[14:12], 1'b0, src_a, imm_i, value);
      7'b0110011: begin
        if (inst[31:25] == 7'b0000000) begin
          ok = alu_model(inst[14:12], 1'b0, src_a, src_b, value);
        end else if (inst[31:25] == 7'b0100000 && inst[14:12] == 3'b000) begin
          ok = alu_model(3'b000, 1'b1, src_a, src_b, value);
        end
      end
      7'b1110011: begin
        if (inst == EBREAK_WORD) begin
          kind = KIND_EBREAK;
        end
      end
      default: ;
    endcase
    if (ok) begin
      kind = KIND_RETIRE;
    end
    res.rd   = inst[11:7];
    res.data = value;
    return kind;
  endfunction

  // ********************************************************************
  // Program generation
  // ********************************************************************

  // Registers drawn from x0..x7 so results get reused often
  function automatic rv_pkg::word_t gen_legal(input logic upper_ok, input logic x0_bias);
    rv_pkg::word_t sel;
    rv_pkg::word_t rd;
    rv_pkg::word_t rs1;
    rv_pkg::word_t rs2;
    rv_pkg::word_t imm;
    rv_pkg::word_t op_pick;
    logic [6:0]    opc;
    logic [2:0]    f3;
    sel = rand_bits(2);
    rd  = rand_bits(3);
    if (x0_bias && rand_bits(1) == 32'd1) begin
      rd = '0;
    end
    rs1 = rand_bits(3);
    rs2 = rand_bits(3);
    if (upper_ok && sel == 32'd3) begin
      imm = rand_bits(20);
      opc = (rand_bits(1) == 32'd1) ? 7'b0110111 : 7'b0010111;
      return {imm[19:0], rd[4:0], opc};
    end
    op_pick = rand_bits(3) % 32'd6;
    case (op_pick)
      32'd0: f3 = 3'b000;
      32'd1: f3 = 3'b010;
      32'd2: f3 = 3'b100;
      32'd3: f3 = 3'b110;
      32'd4: f3 = 3'b111;
      // SUB for OP, ADDI for OP-IMM
      default: f3 = 3'b000;
    endcase
    if (sel[0]) begin
      imm = rand_bits(12);
      return {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0010011};
    end
    opc = (op_pick == 32'd5) ? 7'b0100000 : 7'b0000000;
    return {opc, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
  endfunction

  // Any kept opcode ends in 2'b11, so clearing bit 0 forces illegal
  function automatic rv_pkg::word_t gen_illegal();
    rv_pkg::word_t   w;
    rv_pkg::retire_t scratch;
    w = rand_bits(32);
    if (model_step(w, '0, scratch) != KIND_ILLEGAL) begin
      w[0] = 1'b0;
    end
    return w;
  endfunction

  task automatic build_program(input int len, input logic upper_ok, input logic x0_bias,
                               input int illegal_at);
    for (int i = 0; i < len; i++) begin
      if (i == illegal_at) begin
        prog[i] = gen_illegal();
      end else begin
        prog[i] = gen_legal(upper_ok, x0_bias);
      end
    end
    prog[len] = EBREAK_WORD;
    prog_len  = len + 1;
  endtask

  // ********************************************************************
  // DUT driving, all on the falling edge
  // ********************************************************************

  task automatic reset_core();
    @(negedge clk);
    rst     = 1'b1;
    start   = 1'b0;
    load_we = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
      @(negedge clk);
      load_we   = 1'b1;
      load_addr = i[`RV_IMEM_ADDR_W-1:0];
      load_data = prog[i];
    end
    @(negedge clk);
    load_we = 1'b0;
  endtask

  // Returns at the first RUN cycle, pc 0 on the bus
  task automatic pulse_start();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  // Outputs are sampled mid-cycle where they have settled
  task automatic run_program(input string test);
    rv_pkg::retire_t expected;
    int              kind;
    int              steps;
    int              waited;
    logic            stopped;
    logic            expect_halt;
    for (int r = 0; r < `RV_REG_COUNT; r++) begin
      model_regs[r] = '0;
    end
    model_pc    = '0;
    stopped     = 1'b0;
    expect_halt = 1'b0;
    steps       = 0;
    pulse_start();
    while (!stopped) begin
      if (steps == RUN_LIMIT) begin
        abort_run($sformatf("TIMEOUT: test %s ran %0d cycles without a stop", test, steps));
      end
      kind = model_step(prog[model_pc[`RV_IMEM_ADDR_W+1:2]], model_pc, expected);
      check_word(test, "current_pc", model_pc, current_pc);
      check_flag(test, "halted", 1'b0, halted);
      check_flag(test, "trapped", 1'b0, trapped);
      if (kind == KIND_RETIRE) begin
        check_flag(test, "retire_valid", 1'b1, retire_valid);
        check_reg_idx(test, "retire_rd", expected.rd, retire_rd);
        check_word(test, "retire_data", expected.data, retire_data);
        // x0 keeps reading zero
        if (expected.rd != '0) begin
          model_regs[expected.rd] = expected.data;
        end
        model_pc = (model_pc + 32'd4) % (`RV_IMEM_DEPTH * 4);
      end else begin
        check_flag(test, "retire_valid", 1'b0, retire_valid);
        expect_halt = (kind == KIND_EBREAK);
        stopped     = 1'b1;
      end
      steps++;
      @(negedge clk);
    end
    waited = 0;
    while (!(halted || trapped)) begin
      if (waited == HALT_LIMIT) begin
        abort_run($sformatf("TIMEOUT: test %s never raised halted or trapped", test));
      end
      @(negedge clk);
      waited++;
    end
    check_flag(test, "halted", expect_halt, halted);
    check_flag(test, "trapped", !expect_halt, trapped);
    check_word(test, "stop pc", model_pc, current_pc);
    // Parked core ignores a fresh start
    start = 1'b1;
    repeat (PARK_CYCLES) begin
      @(negedge clk);
      start = 1'b0;
      check_word(test, "parked pc", model_pc, current_pc);
      check_flag(test, "parked retire_valid", 1'b0, retire_valid);
      check_flag(test, "parked halted", expect_halt, halted);
      check_flag(test, "parked trapped", !expect_halt, trapped);
    end
  endtask

  // ********************************************************************
  // Test sequence
  // ********************************************************************

  initial begin
    rv_pkg::word_t pos;
    int            illegal_at;
    clk        = 1'b0;
    rst        = 1'b1;
    start      = 1'b0;
    load_we    = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    lfsr_state = 32'h0017_5ed9;

    reset_core();
    check_word("reset", "current_pc", '0, current_pc);
    check_flag("reset", "retire_valid", 1'b0, retire_valid);
    check_flag("reset", "halted", 1'b0, halted);
    check_flag("reset", "trapped", 1'b0, trapped);

    // Register arithmetic only
    reset_core();
    build_program(30, 1'b0, 1'b0, -1);
    load_program();
    run_program("op_arith");

    // Half the writes aimed at x0
    reset_core();
    build_program(30, 1'b0, 1'b1, -1);
    load_program();
    run_program("x0_writes");

    // LUI and AUIPC mixed in
    reset_core();
    build_program(30, 1'b1, 1'b0, -1);
    load_program();
    run_program("upper_imm");

    reset_core();
    build_program(12, 1'b1, 1'b1, -1);
    load_program();
    run_program("ebreak_halt");
    check_word("ebreak_halt", "halt address", 32'd48, current_pc);

    // Illegal word somewhere in the middle, code after it never runs
    pos        = rand_bits(4);
    illegal_at = 4 + int'(pos);
    reset_core();
    build_program(40, 1'b1, 1'b0, illegal_at);
    load_program();
    run_program("illegal_trap");
    check_word("illegal_trap", "trap address", illegal_at * 4, current_pc);
    check_flag("illegal_trap", "trapped", 1'b1, trapped);

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- include/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// ********************************************************************
// Core widths
// ********************************************************************

// Register and pc width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_REG_COUNT 32

// Register index width
`define RV_REG_IDX_W 5

// ********************************************************************
// Instruction memory geometry
// ********************************************************************

// Depth in 32-bit words
`define RV_IMEM_DEPTH 64

// Word address width, log2 of the depth
`define RV_IMEM_ADDR_W 6

`endif

//--- rtl/alu.sv
`default_nettype none

module alu (
  input  wire rv_pkg::alu_op_e op,
  input  wire rv_pkg::word_t   a,
  input  wire rv_pkg::word_t   b,
  output rv_pkg::word_t        result
);

  // Signed compare, shared by SLT and SLTI
  logic less_signed;

  assign less_signed = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      rv_pkg::ALU_ADD:    result = a + b;
      // Wraps modulo 2^32 like the ISA asks
      rv_pkg::ALU_SUB:    result = a - b;
      rv_pkg::ALU_SLT:    result = {31'b0, less_signed};
      rv_pkg::ALU_XOR:    result = a ^ b;
      rv_pkg::ALU_OR:     result = a | b;
      rv_pkg::ALU_AND:    result = a & b;
      // LUI, b already holds the upper immediate
      rv_pkg::ALU_PASS_B: result = b;
      default:            result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/core_control.sv
`default_nettype none

module core_control (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire logic          start,
  input  wire logic          load_we,
  input  wire logic          is_ebreak,
  input  wire logic          illegal,
  output rv_pkg::core_state_e state,
  output logic               pc_en,
  output logic               reg_wen_gate,
  output logic               mem_we,
  output logic               halted,
  output logic               trapped
);

  rv_pkg::core_state_e state_q;
  rv_pkg::core_state_e state_d;

  // Current instruction may retire
  logic retire_ok;

  // ********************************************************************
  // Run-state machine
  // ********************************************************************

  always_comb begin
    state_d = state_q;
    case (state_q)
      rv_pkg::ST_IDLE: begin
        if (start) begin
          state_d = rv_pkg::ST_RUN;
        end
      end
      rv_pkg::ST_RUN: begin
        // EBREAK and illegal never coincide in the decoder
        if (is_ebreak) begin
          state_d = rv_pkg::ST_HALTED;
        end else if (illegal) begin
          state_d = rv_pkg::ST_TRAPPED;
        end
      end
      // Terminal until reset
      default: state_d = state_q;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= rv_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ********************************************************************
  // Gates and status
  // ********************************************************************

  assign retire_ok = (state_q == rv_pkg::ST_RUN) && !is_ebreak && !illegal;

  assign state        = state_q;
  assign pc_en        = retire_ok;
  assign reg_wen_gate = retire_ok;
  // Program loads only while the core is parked
  assign mem_we       = load_we && (state_q == rv_pkg::ST_IDLE);
  assign halted       = (state_q == rv_pkg::ST_HALTED);
  assign trapped      = (state_q == rv_pkg::ST_TRAPPED);

  // Once started, only reset brings the core back to IDLE
  no_return_to_idle: assert property (
    @(posedge clk) disable iff (rst)
    state_q != rv_pkg::ST_IDLE |=> state_q != rv_pkg::ST_IDLE
  ) else $error("core returned to IDLE without reset");

  // Halt is sticky and never turns into a trap
  halt_sticky: assert property (
    @(posedge clk) disable iff (rst)
    halted |=> halted && !trapped
  ) else $error("halted dropped or trapped rose after halt");

  // No program write lands once the core has left IDLE
  no_late_load: assert property (
    @(posedge clk) disable iff (rst)
    state_q != rv_pkg::ST_IDLE |=> !mem_we
  ) else $error("instruction memory written outside IDLE");

endmodule

`default_nettype wire

//--- rtl/decode_if.sv
`default_nettype none

// Decoded instruction bundle, decoder to datapath
interface decode_if;

  // Register indices straight from the instruction fields
  rv_pkg::reg_idx_t rd;
  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;

  // Immediate, already sign-extended or shifted into place
  rv_pkg::word_t imm;

  // Operation and operand selects
  rv_pkg::alu_op_e alu_op;
  logic use_imm;
  logic use_pc;

  // Class flags
  logic writes_rd;
  logic is_ebreak;
  logic illegal;

  // Decoder side
  modport producer (
    output rd, rs1, rs2, imm, alu_op, use_imm, use_pc,
    output writes_rd, is_ebreak, illegal
  );

  // Datapath and control side
  modport consumer (
    input rd, rs1, rs2, imm, alu_op, use_imm, use_pc,
    input writes_rd, is_ebreak, illegal
  );

endinterface

`default_nettype wire

//--- rtl/inst_decoder.sv
`default_nettype none

module inst_decoder (
  input  wire rv_pkg::word_t inst,
  decode_if.producer         dec
);

  // Instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // Register indices are taken as-is, unused ones are ignored downstream
  assign dec.rd  = inst[11:7];
  assign dec.rs1 = inst[19:15];
  assign dec.rs2 = inst[24:20];

  // ********************************************************************
  // Class and operation decode
  // ********************************************************************

  always_comb begin
    // Safe defaults, anything not matched below stays illegal
    dec.imm       = '0;
    dec.alu_op    = rv_pkg::ALU_ADD;
    dec.use_imm   = 1'b0;
    dec.use_pc    = 1'b0;
    dec.writes_rd = 1'b0;
    dec.is_ebreak = 1'b0;
    dec.illegal   = 1'b1;

    case (opcode)
      rv_pkg::OPC_LUI: begin
        // Upper immediate straight through
        dec.imm       = {inst[31:12], 12'b0};
        dec.alu_op    = rv_pkg::ALU_PASS_B;
        dec.use_imm   = 1'b1;
        dec.writes_rd = 1'b1;
        dec.illegal   = 1'b0;
      end
      rv_pkg::OPC_AUIPC: begin
        // pc plus upper immediate
        dec.imm       = {inst[31:12], 12'b0};
        dec.alu_op    = rv_pkg::ALU_ADD;
        dec.use_imm   = 1'b1;
        dec.use_pc    = 1'b1;
        dec.writes_rd = 1'b1;
        dec.illegal   = 1'b0;
      end
      rv_pkg::OPC_OP_IMM: begin
        // I-type immediate, sign-extended
        dec.imm     = {{20{inst[31]}}, inst[31:20]};
        dec.use_imm = 1'b1;
        // Shifts and SLTIU fall through as illegal
        case (funct3)
          3'b000: dec.alu_op = rv_pkg::ALU_ADD;
          3'b010: dec.alu_op = rv_pkg::ALU_SLT;
          3'b100: dec.alu_op = rv_pkg::ALU_XOR;
          3'b110: dec.alu_op = rv_pkg::ALU_OR;
          3'b111: dec.alu_op = rv_pkg::ALU_AND;
          default: dec.alu_op = rv_pkg::ALU_ADD;
        endcase
        if (funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111}) begin
          dec.writes_rd = 1'b1;
          dec.illegal   = 1'b0;
        end
      end
      rv_pkg::OPC_OP: begin
        // Register-register, only funct7 of zero except SUB
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000: dec.alu_op = rv_pkg::ALU_ADD;
            3'b010: dec.alu_op = rv_pkg::ALU_SLT;
            3'b100: dec.alu_op = rv_pkg::ALU_XOR;
            3'b110: dec.alu_op = rv_pkg::ALU_OR;
            3'b111: dec.alu_op = rv_pkg::ALU_AND;
            default: dec.alu_op = rv_pkg::ALU_ADD;
          endcase
          if (funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111}) begin
            dec.writes_rd = 1'b1;
            dec.illegal   = 1'b0;
          end
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          dec.alu_op    = rv_pkg::ALU_SUB;
          dec.writes_rd = 1'b1;
          dec.illegal   = 1'b0;
        end
      end
      rv_pkg::OPC_SYSTEM: begin
        // Only the exact EBREAK word, ECALL and CSRs are illegal
        if (inst == rv_pkg::EBREAK_INST) begin
          dec.is_ebreak = 1'b1;
          dec.illegal   = 1'b0;
        end
      end
      default: begin
        dec.illegal = 1'b1;
      end
    endcase
  end

  // Exactly one class per word, the control FSM relies on it
  always_comb begin
    assert ($onehot0({dec.illegal, dec.is_ebreak, dec.writes_rd}))
      else $error("decoder flags illegal, ebreak and writes_rd overlap");
  end

endmodule

`default_nettype wire

//--- rtl/inst_memory.sv
`default_nettype none

`include "rv_defines.svh"

module inst_memory (
  input  wire logic                        clk,
  input  wire logic                        we,
  input  wire logic [`RV_IMEM_ADDR_W-1:0]  waddr,
  input  wire rv_pkg::word_t               wdata,
  input  wire logic [`RV_IMEM_ADDR_W-1:0]  raddr,
  output rv_pkg::word_t                    inst
);

  // ********************************************************************
  // Storage
  // ********************************************************************

  // Program words, filled through the load port before start
  rv_pkg::word_t mem [`RV_IMEM_DEPTH];

  // Load port write
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // ********************************************************************
  // Fetch
  // ********************************************************************

  // Read address is the next pc, so the word for the
  // current pc sits on inst for the whole following cycle
  always_ff @(posedge clk) begin
    inst <= mem[raddr];
  end

endmodule

`default_nettype wire

//--- rtl/pc_counter.sv
`default_nettype none

`include "rv_defines.svh"

module pc_counter (
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire logic      en,
  output rv_pkg::word_t  current_pc,
  output rv_pkg::word_t  next_pc
);

  // Top byte-address bit inside the instruction memory
  localparam int unsigned PC_WRAP_MSB = `RV_IMEM_ADDR_W + 1;

  rv_pkg::word_t pc_q;
  rv_pkg::word_t pc_inc;

  assign pc_inc = pc_q + 32'd4;

  // Hold unless enabled, wrap to the memory size when stepping
  always_comb begin
    next_pc = pc_q;
    if (en) begin
      next_pc = '0;
      next_pc[PC_WRAP_MSB:0] = pc_inc[PC_WRAP_MSB:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= '0;
    end else begin
      pc_q <= next_pc;
    end
  end

  assign current_pc = pc_q;

  // Fetch only ever sees word addresses
  pc_aligned: assert property (
    @(posedge clk) disable iff (rst) current_pc[1:0] == 2'b00
  ) else $error("pc lost word alignment");

endmodule

`default_nettype wire

//--- rtl/register_file.sv
`default_nettype none

`include "rv_defines.svh"

module register_file (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             wen,
  input  wire rv_pkg::reg_idx_t waddr,
  input  wire rv_pkg::word_t    wdata,
  input  wire rv_pkg::reg_idx_t raddr_a,
  input  wire rv_pkg::reg_idx_t raddr_b,
  output rv_pkg::word_t         rdata_a,
  output rv_pkg::word_t         rdata_b
);

  // ********************************************************************
  // Register array
  // ********************************************************************

  rv_pkg::word_t regs [`RV_REG_COUNT];

  // Whole file cleared by reset and x0 never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // ********************************************************************
  // Read ports
  // ********************************************************************

  // Combinational reads with index zero forced to zero
  assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
  assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

//--- rtl/rv_core_top.sv
`default_nettype none

`include "rv_defines.svh"

module rv_core_top (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       start,
  input  wire logic                       load_we,
  input  wire logic [`RV_IMEM_ADDR_W-1:0] load_addr,
  input  wire rv_pkg::word_t              load_data,
  output rv_pkg::word_t                   current_pc,
  output logic                            retire_valid,
  output rv_pkg::reg_idx_t                retire_rd,
  output rv_pkg::word_t                   retire_data,
  output logic                            halted,
  output logic                            trapped
);

  // ********************************************************************
  // Fetch
  // ********************************************************************

  rv_pkg::word_t next_pc;
  rv_pkg::word_t inst;
  logic          pc_en;
  logic          mem_we;

  // Byte pc to word address
  inst_memory u_inst_memory (
    .clk   (clk),
    .we    (mem_we),
    .waddr (load_addr),
    .wdata (load_data),
    .raddr (next_pc[`RV_IMEM_ADDR_W+1:2]),
    .inst  (inst)
  );

  pc_counter u_pc_counter (
    .clk        (clk),
    .rst        (rst),
    .en         (pc_en),
    .current_pc (current_pc),
    .next_pc    (next_pc)
  );

  // ********************************************************************
  // Decode and control
  // ********************************************************************

  decode_if dec_bus ();

  inst_decoder u_inst_decoder (
    .inst (inst),
    .dec  (dec_bus)
  );

  rv_pkg::core_state_e state;
  logic                reg_wen_gate;

  core_control u_core_control (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .load_we      (load_we),
    .is_ebreak    (dec_bus.is_ebreak),
    .illegal      (dec_bus.illegal),
    .state        (state),
    .pc_en        (pc_en),
    .reg_wen_gate (reg_wen_gate),
    .mem_we       (mem_we),
    .halted       (halted),
    .trapped      (trapped)
  );

  // ********************************************************************
  // Execute and write back
  // ********************************************************************

  rv_pkg::word_t   rdata_a;
  rv_pkg::word_t   rdata_b;
  rv_pkg::word_t   operand_a;
  rv_pkg::word_t   operand_b;
  rv_pkg::word_t   alu_result;
  logic            reg_wen;
  rv_pkg::retire_t retire;

  // Write enable doubles as the retire strobe
  assign reg_wen = dec_bus.writes_rd && reg_wen_gate;

  register_file u_register_file (
    .clk     (clk),
    .rst     (rst),
    .wen     (reg_wen),
    .waddr   (dec_bus.rd),
    .wdata   (alu_result),
    .raddr_a (dec_bus.rs1),
    .raddr_b (dec_bus.rs2),
    .rdata_a (rdata_a),
    .rdata_b (rdata_b)
  );

  // AUIPC takes the pc and immediates replace rs2
  assign operand_a = dec_bus.use_pc ? current_pc : rdata_a;
  assign operand_b = dec_bus.use_imm ? dec_bus.imm : rdata_b;

  alu u_alu (
    .op     (dec_bus.alu_op),
    .a      (operand_a),
    .b      (operand_b),
    .result (alu_result)
  );

  // Retire bundle split onto plain ports
  assign retire.rd    = dec_bus.rd;
  assign retire.data  = alu_result;
  assign retire_valid = reg_wen;
  assign retire_rd    = retire.rd;
  assign retire_data  = retire.data;

  // Byte pc one word on, wrapped to the instruction memory
  logic [`RV_IMEM_ADDR_W+1:0] pc_step;

  assign pc_step = current_pc[`RV_IMEM_ADDR_W+1:0] + 3'd4;

  // Every retire leaves the core running at the following word
  retire_steps_pc: assert property (
    @(posedge clk) disable iff (rst)
    retire_valid |=> state == rv_pkg::ST_RUN
      && current_pc == rv_pkg::word_t'($past(pc_step))
  ) else $error("retire did not step the pc by one word");

endmodule

`default_nettype wire

//--- rtl/rv_pkg.sv
`default_nettype none

`include "rv_defines.svh"

package rv_pkg;

  // One machine word: instruction, data or pc
  typedef logic [`RV_XLEN-1:0] word_t;

  // Register index
  typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // ALU operations, PASS_B forwards operand b for LUI
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_SLT    = 3'd2,
    ALU_XOR    = 3'd3,
    ALU_OR     = 3'd4,
    ALU_AND    = 3'd5,
    ALU_PASS_B = 3'd6
  } alu_op_e;

  // Run-state machine encoding
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_RUN     = 2'd1,
    ST_HALTED  = 2'd2,
    ST_TRAPPED = 2'd3
  } core_state_e;

  // One retired result: destination and written value
  typedef struct packed {
    reg_idx_t rd;
    word_t    data;
  } retire_t;

  // The only accepted SYSTEM encoding
  localparam word_t EBREAK_INST = 32'h0010_0073;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_rv_core -f vlog.f -o sim_rv_core

./obj_dir/sim_rv_core 2>&1 | tee sim.log || true

if grep -q "Finished with no errors" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

//--- vlog.f
+incdir+include
rtl/rv_pkg.sv
rtl/decode_if.sv
rtl/inst_memory.sv
rtl/inst_decoder.sv
rtl/register_file.sv
rtl/alu.sv
rtl/pc_counter.sv
rtl/core_control.sv
rtl/rv_core_top.sv
bench/tb_rv_core.sv
